//--- source/stream_pkg.sv
`default_nettype none

package stream_pkg;

	// Default word width in bytes, passed down from the top level as BYTES
	parameter int DATA_BYTES = 4;

	// Default Wishbone address width
	parameter int ADDR_BITS = 8;

	// Request kind, taken from the write flag in the stream user field
	typedef enum logic
	{
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} op_t;

	// Decoded request travelling from decode to execute
	typedef struct packed
	{
		op_t                     op;
		logic [ADDR_BITS-1:0]    index;
		logic                    in_range;
		logic [DATA_BYTES*8-1:0] data;
	} req_item_t;

	// Read response, only the data word for now
	typedef struct packed
	{
		logic [DATA_BYTES*8-1:0] data;
	} rsp_item_t;

endpackage

`default_nettype wire

//--- source/axis_register.sv
`timescale 1ns/1ps
`default_nettype none

module axis_register
#(
	parameter int WIDTH = 8
) (
	input  wire logic             clk,
	input  wire logic             sresetn,

	output logic                  in_ready,
	input  wire logic             in_valid,
	input  wire logic [WIDTH-1:0] in_data,

	input  wire logic             out_ready,
	output logic                  out_valid,
	output logic      [WIDTH-1:0] out_data
);

	logic             main_valid;
	logic [WIDTH-1:0] main_data;
	logic             skid_valid;
	logic [WIDTH-1:0] skid_data;

	logic main_free;

	// Main slot can load when empty or when it is being drained this cycle
	assign main_free = out_ready || !main_valid;

	// Ready comes straight from a flop
	assign in_ready  = !skid_valid;
	assign out_valid = main_valid;
	assign out_data  = main_data;

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			main_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (main_free)
		begin
			// Skid contents always go first to keep order
			main_valid <= skid_valid || in_valid;
			skid_valid <= 1'b0;
		end else if (in_valid && in_ready)
		begin
			skid_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (main_free)
		begin
			main_data <= skid_valid ? skid_data : in_data;
		end else if (in_valid && in_ready)
		begin
			skid_data <= in_data;
		end
	end

endmodule

`default_nettype wire

//--- source/wb_axis_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module wb_axis_bridge
#(
	parameter int BYTES = stream_pkg::DATA_BYTES,
	parameter int ADDR_BITS = stream_pkg::ADDR_BITS,
	// Emit reads on the outbound stream too, not only writes
	parameter bit OUTPUT_READS = 1'b0,
	// Up to 2**LOG2_NUM_OUTSTANDING reads may wait for their data
	parameter int LOG2_NUM_OUTSTANDING = 2
) (
	input  wire logic                 clk,
	input  wire logic                 sresetn,

	// Wishbone pipelined slave, cyc assumed high
	input  wire logic                 wb_stb,
	input  wire logic                 wb_we,
	input  wire logic [ADDR_BITS-1:0] wb_addr,
	input  wire logic [BYTES*8-1:0]   wb_data_i,
	output logic      [BYTES*8-1:0]   wb_data_o,
	output logic                      wb_ack,
	output logic                      wb_stall,

	// Returned read data
	output logic                      axis_i_tready,
	input  wire logic                 axis_i_tvalid,
	input  wire logic [BYTES*8-1:0]   axis_i_tdata,

	// Request items, tuser holds {we, addr}
	input  wire logic                 axis_o_tready,
	output logic                      axis_o_tvalid,
	output logic      [BYTES*8-1:0]   axis_o_tdata,
	output logic      [ADDR_BITS:0]   axis_o_tuser
);

	logic                          req_ready;
	logic                          req_valid;
	logic [LOG2_NUM_OUTSTANDING:0] outstanding;
	logic                          reads_full;
	logic                          read_accepted;
	logic                          write_accepted;
	logic                          read_returned;

	// Count reaches exactly 2**LOG2_NUM_OUTSTANDING at most, so the top bit flags full
	assign reads_full     = outstanding[LOG2_NUM_OUTSTANDING];
	assign read_accepted  = wb_stb && !wb_we && !wb_stall;
	assign write_accepted = wb_stb && wb_we && !wb_stall;
	assign read_returned  = axis_i_tready && axis_i_tvalid;
	assign axis_i_tready  = outstanding != '0;

	always_comb
	begin
		wb_stall = 1'b0;
		if (wb_stb)
		begin
			if (wb_we)
			begin
				// Writes wait for earlier reads so acks stay in request order
				wb_stall = !req_ready || (outstanding != '0);
			end else
			begin
				wb_stall = reads_full || (OUTPUT_READS && !req_ready);
			end
		end
	end

	assign req_valid = wb_stb && !wb_stall && (wb_we || OUTPUT_READS);

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			outstanding <= '0;
		end else if (read_accepted && !read_returned)
		begin
			outstanding <= outstanding + 1'b1;
		end else if (!read_accepted && read_returned)
		begin
			outstanding <= outstanding - 1'b1;
		end
	end

	// A write is done once it sits in the stream, a read when its word comes back
	always_ff @(posedge clk)
	begin
		if (!sresetn)
			wb_ack <= 1'b0;
		else
			wb_ack <= write_accepted || read_returned;
	end

	always_ff @(posedge clk)
	begin
		if (read_returned)
			wb_data_o <= axis_i_tdata;
	end

	axis_register
	#(
		.WIDTH(BYTES*8 + ADDR_BITS + 1)
	) req_reg (
		.clk(clk),
		.sresetn(sresetn),
		.in_ready(req_ready),
		.in_valid(req_valid),
		.in_data({wb_we, wb_addr, wb_data_i}),
		.out_ready(axis_o_tready),
		.out_valid(axis_o_tvalid),
		.out_data({axis_o_tuser, axis_o_tdata})
	);

endmodule

`default_nettype wire

//--- source/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode
#(
	parameter int BYTES = stream_pkg::DATA_BYTES,
	parameter int ADDR_BITS = stream_pkg::ADDR_BITS,
	parameter int NUM_REGS = 8
) (
	input  wire logic                 clk,
	input  wire logic                 sresetn,

	output logic                      in_ready,
	input  wire logic                 in_valid,
	input  wire logic [BYTES*8-1:0]   in_data,
	input  wire logic [ADDR_BITS:0]   in_user,

	input  wire logic                 out_ready,
	output logic                      out_valid,
	output stream_pkg::req_item_t     out_item
);

	import stream_pkg::*;

	req_item_t decoded;

	// User field is {we, addr}
	always_comb
	begin
		decoded.op       = in_user[ADDR_BITS] ? OP_WRITE : OP_READ;
		decoded.index    = in_user[ADDR_BITS-1:0];
		decoded.in_range = 32'(in_user[ADDR_BITS-1:0]) < NUM_REGS;
		decoded.data     = in_data;
	end

	// Stage empties or drains this cycle
	assign in_ready = out_ready || !out_valid;

	always_ff @(posedge clk)
	begin
		if (!sresetn)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_ready && in_valid)
			out_item <= decoded;
	end

endmodule

`default_nettype wire

//--- source/reg_execute.sv
`timescale 1ns/1ps
`default_nettype none

module reg_execute
#(
	parameter int BYTES = stream_pkg::DATA_BYTES,
	parameter int NUM_REGS = 8
) (
	input  wire logic             clk,
	input  wire logic             sresetn,

	output logic                  in_ready,
	input  wire logic             in_valid,
	input  wire stream_pkg::req_item_t in_item,

	input  wire logic             out_ready,
	output logic                  out_valid,
	output stream_pkg::rsp_item_t out_rsp
);

	import stream_pkg::*;

	localparam int IDX_BITS = $clog2(NUM_REGS);

	// Index 0 is the write counter, the array covers the writable ones
	logic [BYTES*8-1:0]  regs [1:NUM_REGS-1];
	logic [BYTES*8-1:0]  write_count;
	logic [BYTES*8-1:0]  read_word;
	logic [IDX_BITS-1:0] idx;
	logic                accept;

	assign idx      = in_item.index[IDX_BITS-1:0];
	assign in_ready = !out_valid || out_ready;
	assign accept   = in_valid && in_ready;

	always_comb
	begin
		if (!in_item.in_range)
			read_word = '0;
		else if (idx == '0)
			read_word = write_count;
		else
			read_word = regs[idx];
	end

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			write_count <= '0;
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (accept && in_item.op == OP_WRITE)
		begin
			// Counts every write, even ones that land nowhere
			write_count <= write_count + 1'b1;
			if (in_item.in_range && idx != '0)
				regs[idx] <= in_item.data;
		end
	end

	// Only reads produce a response
	always_ff @(posedge clk)
	begin
		if (!sresetn)
			out_valid <= 1'b0;
		else if (accept && in_item.op == OP_READ)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept && in_item.op == OP_READ)
			out_rsp.data <= read_word;
	end

endmodule

`default_nettype wire

//--- source/result_stream.sv
`timescale 1ns/1ps
`default_nettype none

module result_stream
#(
	parameter int BYTES = stream_pkg::DATA_BYTES
) (
	input  wire logic             clk,
	input  wire logic             sresetn,

	output logic                  in_ready,
	input  wire logic             in_valid,
	input  wire stream_pkg::rsp_item_t in_rsp,

	input  wire logic             out_ready,
	output logic                  out_valid,
	output stream_pkg::rsp_item_t out_rsp
);

	import stream_pkg::*;

	logic [BYTES*8-1:0] mem [2];
	logic               wr_ptr;
	logic               rd_ptr;
	logic [1:0]         count;
	logic               push;
	logic               pop;

	assign in_ready     = count != 2'd2;
	assign out_valid    = count != 2'd0;
	assign out_rsp.data = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else
		begin
			if (push)
				wr_ptr <= !wr_ptr;
			if (pop)
				rd_ptr <= !rd_ptr;
			// Simultaneous push and pop leaves the fill level alone
			if (push && !pop)
				count <= count + 2'd1;
			else if (pop && !push)
				count <= count - 2'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_rsp.data;
	end

endmodule

`default_nettype wire

//--- source/wb_regs_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_regs_top
#(
	parameter int BYTES = stream_pkg::DATA_BYTES,
	parameter int ADDR_BITS = stream_pkg::ADDR_BITS,
	parameter int NUM_REGS = 8,
	parameter int LOG2_NUM_OUTSTANDING = 2
) (
	input  wire logic                 clk,
	input  wire logic                 sresetn,

	input  wire logic                 wb_stb,
	input  wire logic                 wb_we,
	input  wire logic [ADDR_BITS-1:0] wb_addr,
	input  wire logic [BYTES*8-1:0]   wb_data_i,
	output logic      [BYTES*8-1:0]   wb_data_o,
	output logic                      wb_ack,
	output logic                      wb_stall
);

	import stream_pkg::*;

	logic                 req_ready;
	logic                 req_valid;
	logic [BYTES*8-1:0]   req_data;
	logic [ADDR_BITS:0]   req_user;

	logic                 dec_ready;
	logic                 dec_valid;
	req_item_t            dec_item;

	logic                 exe_ready;
	logic                 exe_valid;
	rsp_item_t            exe_rsp;

	logic                 ret_ready;
	logic                 ret_valid;
	rsp_item_t            ret_rsp;

	// Reads must reach the execute stage, so the bridge emits them
	wb_axis_bridge
	#(
		.BYTES(BYTES),
		.ADDR_BITS(ADDR_BITS),
		.OUTPUT_READS(1'b1),
		.LOG2_NUM_OUTSTANDING(LOG2_NUM_OUTSTANDING)
	) bridge (
		.clk(clk),
		.sresetn(sresetn),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_addr(wb_addr),
		.wb_data_i(wb_data_i),
		.wb_data_o(wb_data_o),
		.wb_ack(wb_ack),
		.wb_stall(wb_stall),
		.axis_i_tready(ret_ready),
		.axis_i_tvalid(ret_valid),
		.axis_i_tdata(ret_rsp.data),
		.axis_o_tready(req_ready),
		.axis_o_tvalid(req_valid),
		.axis_o_tdata(req_data),
		.axis_o_tuser(req_user)
	);

	cmd_decode
	#(
		.BYTES(BYTES),
		.ADDR_BITS(ADDR_BITS),
		.NUM_REGS(NUM_REGS)
	) decode (
		.clk(clk),
		.sresetn(sresetn),
		.in_ready(req_ready),
		.in_valid(req_valid),
		.in_data(req_data),
		.in_user(req_user),
		.out_ready(dec_ready),
		.out_valid(dec_valid),
		.out_item(dec_item)
	);

	reg_execute
	#(
		.BYTES(BYTES),
		.NUM_REGS(NUM_REGS)
	) execute (
		.clk(clk),
		.sresetn(sresetn),
		.in_ready(dec_ready),
		.in_valid(dec_valid),
		.in_item(dec_item),
		.out_ready(exe_ready),
		.out_valid(exe_valid),
		.out_rsp(exe_rsp)
	);

	result_stream
	#(
		.BYTES(BYTES)
	) result (
		.clk(clk),
		.sresetn(sresetn),
		.in_ready(exe_ready),
		.in_valid(exe_valid),
		.in_rsp(exe_rsp),
		.out_ready(ret_ready),
		.out_valid(ret_valid),
		.out_rsp(ret_rsp)
	);

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
	parameter int PERIOD_NS = 4
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2.0) clk = !clk;
	end

endmodule

`default_nettype wire

//--- sim/wb_regs_props.sv
`timescale 1ns/1ps
`default_nettype none

module wb_regs_props
(
	input wire logic clk,
	input wire logic sresetn,
	input wire logic wb_stb,
	input wire logic wb_stall,
	input wire logic wb_ack
);

	int          fail_count = 0;
	logic [31:0] req_count;
	logic [31:0] ack_count;
	logic [7:0]  idle_cycles;

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			req_count   <= '0;
			ack_count   <= '0;
			idle_cycles <= '0;
		end else
		begin
			if (wb_stb && !wb_stall)
				req_count <= req_count + 1;
			if (wb_ack)
				ack_count <= ack_count + 1;
			// Saturating count of cycles without strobe
			if (wb_stb)
				idle_cycles <= '0;
			else if (idle_cycles != 8'hff)
				idle_cycles <= idle_cycles + 1;
		end
	end

	// Every ack needs an accepted request still waiting for it
	ack_has_request: assert property (@(posedge clk) disable iff (!sresetn)
		wb_ack |-> req_count != ack_count)
	else
	begin
		fail_count++;
		$error("ack with no request pending");
	end

	quiet_in_reset: assert property (@(posedge clk)
		!sresetn |=> !wb_ack && !wb_stall)
	else
	begin
		fail_count++;
		$error("ack or stall high during or right after reset");
	end

	// A quiet bus has drained all reads
	balanced_when_idle: assert property (@(posedge clk) disable iff (!sresetn)
		idle_cycles >= 8'd12 |-> req_count == ack_count)
	else
	begin
		fail_count++;
		$error("request and ack counts differ on an idle bus");
	end

endmodule

bind wb_regs_top wb_regs_props props
(
	.clk(clk),
	.sresetn(sresetn),
	.wb_stb(wb_stb),
	.wb_stall(wb_stall),
	.wb_ack(wb_ack)
);

`default_nettype wire

//--- sim/wb_regs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wb_regs_tb;

	localparam int BYTES         = 4;
	localparam int WIDTH         = BYTES * 8;
	localparam int ADDR_BITS     = 8;
	localparam int NUM_REGS      = 8;
	localparam int LOG2_NUM_OUTS = 2;
	localparam int CLK_PERIOD_NS = 4;
	// Transactions over all five tests
	localparam int NUM_TXNS      = 7 * NUM_REGS + 7;
	localparam int WATCHDOG_NS   = (NUM_TXNS * 20 + 200) * CLK_PERIOD_NS;

	typedef struct packed
	{
		logic             is_read;
		logic [WIDTH-1:0] data;
		logic [31:0]      cycle;
	} exp_entry_t;

	logic                 clk;
	logic                 sresetn;
	logic                 wb_stb;
	logic                 wb_we;
	logic [ADDR_BITS-1:0] wb_addr;
	logic [WIDTH-1:0]     wb_data_i;
	logic [WIDTH-1:0]     wb_data_o;
	logic                 wb_ack;
	logic                 wb_stall;

	logic [WIDTH-1:0] model_regs [NUM_REGS];
	logic [WIDTH-1:0] model_writes;
	exp_entry_t       exp_q [$];
	logic [31:0]      rng = 32'h66e;
	logic [31:0]      cycle_no = '0;
	int               checks = 0;
	int               errors = 0;
	int               reqs = 0;
	int               acks = 0;

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) clock_gen (.clk(clk));

	wb_regs_top
	#(
		.BYTES(BYTES),
		.ADDR_BITS(ADDR_BITS),
		.NUM_REGS(NUM_REGS),
		.LOG2_NUM_OUTSTANDING(LOG2_NUM_OUTS)
	) uut (
		.clk(clk),
		.sresetn(sresetn),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_addr(wb_addr),
		.wb_data_i(wb_data_i),
		.wb_data_o(wb_data_o),
		.wb_ack(wb_ack),
		.wb_stall(wb_stall)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic logic [WIDTH-1:0] model_read(input logic [ADDR_BITS-1:0] addr);
		if (32'(addr) >= NUM_REGS)
			return '0;
		else if (addr == '0)
			return model_writes;
		return model_regs[addr];
	endfunction

	task automatic check_value(input string name, input logic [WIDTH-1:0] got,
		input logic [WIDTH-1:0] expected);
		checks++;
		assert (got === expected)
		else
		begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, expected);
		end
	endtask

	// Monitor samples mid-cycle, where inputs and registered outputs are settled
	always @(negedge clk)
	begin
		exp_entry_t e;
		if (sresetn)
		begin
			cycle_no = cycle_no + 1;
			if (wb_ack)
			begin
				acks++;
				checks++;
				assert (exp_q.size() != 0)
				else
				begin
					errors++;
					$display("Ack seen with no request waiting for it");
				end
				if (exp_q.size() != 0)
				begin
					e = exp_q.pop_front();
					if (e.is_read)
						check_value("wb_data_o", wb_data_o, e.data);
					else
					begin
						checks++;
						assert (cycle_no == e.cycle + 1)
						else
						begin
							errors++;
							$display("Write ack came %0d cycles after acceptance",
								cycle_no - e.cycle);
						end
					end
				end
			end
			// Request accepted at the coming edge
			if (wb_stb && !wb_stall)
			begin
				reqs++;
				e.is_read = !wb_we;
				e.data    = model_read(wb_addr);
				e.cycle   = cycle_no;
				exp_q.push_back(e);
				if (wb_we)
				begin
					model_writes = model_writes + 1;
					if (32'(wb_addr) < NUM_REGS && wb_addr != '0)
						model_regs[wb_addr] = wb_data_i;
				end
			end
		end
	end

	// Called 1 ns after a rising edge, leaves strobe high once accepted
	task automatic issue(input logic we, input logic [ADDR_BITS-1:0] addr,
		input logic [WIDTH-1:0] data);
		bit done;
		done      = 1'b0;
		wb_stb    = 1'b1;
		wb_we     = we;
		wb_addr   = addr;
		wb_data_i = data;
		while (!done)
		begin
			@(negedge clk);
			done = !wb_stall;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic release_bus();
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_addr   = '0;
		wb_data_i = '0;
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0)
			@(negedge clk);
		@(posedge clk);
		#1;
	endtask

	task automatic single(input logic we, input logic [ADDR_BITS-1:0] addr,
		input logic [WIDTH-1:0] data);
		issue(we, addr, data);
		release_bus();
		wait_idle();
	endtask

	task automatic report_test(input string name, input int start_errors);
		$display("%-32s errors %0d", name, errors - start_errors);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with %0d acks pending",
			WATCHDOG_NS, exp_q.size());
		$display("Something failed");
		$finish;
	end

	initial
	begin
		int start;
		sresetn = 1'b0;
		release_bus();
		model_writes = '0;
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;
		repeat (3) @(posedge clk);
		#1;
		sresetn = 1'b1;

		start = errors;
		repeat (4)
		begin
			@(negedge clk);
			checks++;
			assert (!wb_ack && !wb_stall)
			else
			begin
				errors++;
				$display("Ack or stall high on an idle bus after reset");
			end
		end
		@(posedge clk);
		#1;
		for (int i = 0; i < NUM_REGS; i++)
			single(1'b0, ADDR_BITS'(i), '0);
		report_test("reset state", start);

		start = errors;
		for (int i = 1; i < NUM_REGS; i++)
			single(1'b1, ADDR_BITS'(i), next_rand());
		for (int i = 1; i < NUM_REGS; i++)
			single(1'b0, ADDR_BITS'(i), '0);
		report_test("write and read back", start);

		start = errors;
		single(1'b0, '0, '0);
		single(1'b1, '0, next_rand());
		single(1'b1, '0, next_rand());
		single(1'b0, '0, '0);
		single(1'b0, 1, '0);
		report_test("write counter", start);

		start = errors;
		single(1'b0, ADDR_BITS'(NUM_REGS), '0);
		single(1'b0, '1, '0);
		single(1'b1, ADDR_BITS'(NUM_REGS), next_rand());
		single(1'b1, '1, next_rand());
		for (int i = 0; i < NUM_REGS; i++)
			single(1'b0, ADDR_BITS'(i), '0);
		report_test("out of range access", start);

		// Strobe stays high across stalls to keep reads in flight
		start = errors;
		for (int i = 0; i < 3 * NUM_REGS; i++)
			issue(1'b0, ADDR_BITS'(next_rand() % NUM_REGS), '0);
		release_bus();
		// Long quiet stretch while the last reads drain
		repeat (16)
			@(posedge clk);
		#1;
		wait_idle();
		checks++;
		assert (acks == reqs)
		else
		begin
			errors++;
			$display("** Error: acks = 0x%h, expected 0x%h", acks, reqs);
		end
		report_test("back to back reads", start);

		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, uut.props.fail_count);
		if (errors == 0 && uut.props.fail_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
source/stream_pkg.sv
source/axis_register.sv
source/wb_axis_bridge.sv
source/cmd_decode.sv
source/reg_execute.sv
source/result_stream.sv
source/wb_regs_top.sv
sim/tb_clock.sv
sim/wb_regs_props.sv
sim/wb_regs_tb.sv

//--- Makefile
TOP = wb_regs_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -qx "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
